//--- dv/hwag_vectors.txt
# cmd a b c in hex: W addr data 0 | R addr expect tolerance | T teeth period gap
# C what expect 0, what is 0 started, 1 irq, 2 acnt_top pulsed, 3 acnt max, 4 vr_out rose
W 05 0005 0
W 06 0007 0
W 01 0100 0
W 03 0300 0
R 05 0005 0
R 01 0100 0
W 40 00A0 0
W 41 0080 0
R 41 0020 0
W 42 000F 0
W 43 0003 0
R 42 000C 0
# Filter on with a length of four cycles
W 00 0003 0
W 40 0005 0
R 40 0025 0
T 3 8 0
C 4 0 0
T 2 20 0
C 4 1 0
W 41 0024 0
R 40 0001 0
C 0 0 0
# Sync on the first gap
T 4 200 1
T 1 200 0
R 45 0600 3
R 46 0000 0
C 0 1 0
C 1 0 0
C 2 0 0
# One revolution ending in the expected gap
T 5 200 1
T 1 200 0
C 1 1 0
C 2 1 0
C 3 0EFF 0
R 44 0004 0
W 44 0004 0
R 44 0000 0
C 1 0 0
# Early gap
T 2 200 1
T 1 200 0
R 44 0008 0
C 1 1 0
# Events with the enables cleared
W 43 000C 0
W 44 000F 0
T 2 200 1
T 1 200 0
R 44 0000 0
C 1 0 0
W 47 0002 0
R 47 0002 0

//--- all.f
+incdir+hdl
hdl/hwag_pkg.sv
hdl/cmp_counter.sv
hdl/vr_input_filter.sv
hdl/hwag_regs.sv
hdl/tooth_tracker.sv
hdl/angle_gen.sv
hdl/hwag_top.sv
dv/hwag_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module hwag_tb -o hwag_sim
./obj_dir/hwag_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation did not pass"
  exit 1
fi

//--- dv/hwag_tb.sv
// Testbench for the crank angle generator, replays the command vectors
// Drives the host bus and the VR pin, checks reads, sync state, flags and angle
`timescale 1ns/1ps
`default_nettype none

module hwag_tb
  import hwag_pkg::*;
();

  localparam int CLK_HALF   = 20;
  localparam int DRIVE_SKEW = 2;

  logic          clk;
  logic          rst_n;
  logic          vr_in;
  hwag_bus_req_t bus;
  hwag_word_t    rdata;
  logic          vr_out;
  logic          irq;
  logic          started;
  logic          acnt_top;
  acnt_t         acnt;

  // Command table loaded from the vector file
  logic [7:0]  op_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] c_q[$];
  logic        parse_ok;
  logic        vectors_loaded;
  longint      watch_ns;

  int          pass_cnt;
  int          fail_cnt;
  logic        cur_ok;

  // Event counters kept by the monitor
  int unsigned vr_rise_cnt;
  int unsigned top_cnt;
  int unsigned rise_seen;
  int unsigned top_seen;
  acnt_t       acnt_max;
  logic        vr_out_q;

  hwag_top hwag_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .vr_in    (vr_in),
    .bus      (bus),
    .rdata    (rdata),
    .vr_out   (vr_out),
    .irq      (irq),
    .started  (started),
    .acnt_top (acnt_top),
    .acnt     (acnt)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vr_out_q    <= 1'b0;
      vr_rise_cnt <= 0;
      top_cnt     <= 0;
      acnt_max    <= '0;
    end else begin
      vr_out_q <= vr_out;
      if (vr_out && !vr_out_q) begin
        vr_rise_cnt <= vr_rise_cnt + 1;
      end
      if (acnt_top) begin
        top_cnt <= top_cnt + 1;
      end
      if (acnt > acnt_max) begin
        acnt_max <= acnt;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_SKEW;
  endtask

  task automatic bus_idle();
    int unsigned n;
    n = $urandom % 4;
    repeat (n) next_cycle();
  endtask

  task automatic bus_write(logic [7:0] addr, hwag_word_t data);
    bus_idle();
    bus.we    = 1'b1;
    bus.addr  = addr;
    bus.wdata = data;
    next_cycle();
    bus = '0;
  endtask

  // rdata is loaded at the edge that samples re
  task automatic bus_read(logic [7:0] addr, output hwag_word_t data);
    bus_idle();
    bus.re   = 1'b1;
    bus.addr = addr;
    next_cycle();
    bus  = '0;
    data = rdata;
  endtask

  // Rising edge starts each tooth, the last one spans three periods for a gap
  task automatic run_teeth(int unsigned count, int unsigned period, logic gap);
    int unsigned high;
    int unsigned low;
    high = period / 4;
    for (int unsigned i = 0; i < count; i++) begin
      low = (gap && i == count - 1) ? 3 * period - high : period - high;
      vr_in = 1'b1;
      repeat (high) next_cycle();
      vr_in = 1'b0;
      repeat (low) next_cycle();
    end
  endtask

  task automatic check_word(string name, hwag_word_t got, hwag_word_t exp, hwag_word_t tol);
    hwag_word_t diff;
    diff = (got > exp) ? got - exp : exp - got;
    if (diff > tol) begin
      $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
      cur_ok = 1'b0;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0d ns %s: got %b, expected %b", $time, name, got, exp);
      cur_ok = 1'b0;
    end
  endtask

  task automatic check_angle(string name, acnt_t got, acnt_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
      cur_ok = 1'b0;
    end
  endtask

  // Pulse selectors compare against the count seen at the previous check
  task automatic compare_state(logic [31:0] sel, logic [31:0] exp);
    case (sel)
      0: check_flag("started", started, exp[0]);
      1: check_flag("irq", irq, exp[0]);
      2: begin
        check_flag("acnt_top", top_cnt != top_seen, exp[0]);
        top_seen = top_cnt;
      end
      3: check_angle("acnt max", acnt_max, acnt_t'(exp));
      4: begin
        check_flag("vr_out rise", vr_rise_cnt != rise_seen, exp[0]);
        rise_seen = vr_rise_cnt;
      end
      default: begin
        $display("compare selector %0d does not exist", sel);
        cur_ok = 1'b0;
      end
    endcase
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    longint      tooth_cycles;
    tooth_cycles = 0;
    fd = $fopen("dv/hwag_vectors.txt", "r");
    if (fd == 0) begin
      $display("vector file dv/hwag_vectors.txt could not be opened");
      parse_ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1) begin
          op = line.getc(0);
          if (op != "#") begin
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
            if (n != 3) begin
              $display("vector line is malformed: %s", line);
              parse_ok = 1'b0;
            end
            op_q.push_back(op);
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
            if (op == "T") begin
              tooth_cycles += longint'(a) * longint'(b) + (c != 0 ? 2 * longint'(b) : 0);
            end
          end
        end
      end
      $fclose(fd);
    end
    if (op_q.size() == 0) begin
      $display("no commands were read from the vector file");
      parse_ok = 1'b0;
    end
    // Twice the tooth time plus room for bus traffic and reset
    watch_ns = tooth_cycles * 2 * 2 * CLK_HALF + 50000 + 1000 * op_q.size();
  endtask

  initial begin
    hwag_word_t rd;
    rst_n          = 1'b0;
    vr_in          = 1'b0;
    bus            = '0;
    parse_ok       = 1'b1;
    vectors_loaded = 1'b0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    rise_seen      = 0;
    top_seen       = 0;
    void'($urandom(32'h52789f83));
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (3) @(posedge clk);
    #DRIVE_SKEW;
    rst_n = 1'b1;
    next_cycle();
    foreach (op_q[i]) begin
      cur_ok = 1'b1;
      case (op_q[i])
        "W": bus_write(a_q[i][7:0], b_q[i][15:0]);
        "R": begin
          bus_read(a_q[i][7:0], rd);
          check_word($sformatf("rdata[%02h]", a_q[i][7:0]), rd, b_q[i][15:0], c_q[i][15:0]);
        end
        "T": run_teeth(a_q[i], b_q[i], c_q[i] != 0);
        "C": compare_state(a_q[i], b_q[i]);
        default: begin
          $display("command %c on vector %0d is not known", op_q[i], i);
          cur_ok = 1'b0;
        end
      endcase
      if (cur_ok) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      $display("test %0d %c %h %h %h: %s", i, op_q[i], a_q[i], b_q[i], c_q[i],
               cur_ok ? "ok" : "failed");
    end
    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && parse_ok) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    wait (vectors_loaded);
    #(watch_ns);
    $display("watchdog expired after %0d ns with commands still running", watch_ns);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/hwag_top.sv
// Top level of the crank angle generator
// Host bus and VR pin in, angle, sync state and interrupt out
`timescale 1ns/1ps
`default_nettype none

module hwag_top
  import hwag_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          vr_in,
  input  wire hwag_bus_req_t bus,
  output hwag_word_t         rdata,
  output logic               vr_out,
  output logic               irq,
  output logic               started,
  output logic               acnt_top,
  output acnt_t              acnt
);

  hwag_cfg_t cfg;
  hwag_irq_t evt;
  hwag_irq_t trk_evt;
  pcnt_t     period;
  tcnt_t     tooth;
  logic      thvl_load;
  logic      edge0;
  logic      edge1;
  logic      gap_point_now;

  hwag_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (bus),
    .rdata     (rdata),
    .cfg       (cfg),
    .evt       (evt),
    .period    (period),
    .tooth     (tooth),
    .thvl_load (thvl_load),
    .irq       (irq)
  );

  vr_input_filter u_filter (
    .clk    (clk),
    .rst_n  (rst_n),
    .vr_in  (vr_in),
    .cfg    (cfg),
    .vr_out (vr_out),
    .edge0  (edge0),
    .edge1  (edge1)
  );

  tooth_tracker u_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .edge0         (edge0),
    .cfg           (cfg),
    .thvl_load     (thvl_load),
    .thvl_data     (tcnt_t'(bus.wdata)),
    .period        (period),
    .tooth         (tooth),
    .started       (started),
    .gap_point_now (gap_point_now),
    .evt           (trk_evt)
  );

  // Tooth edge event comes from the filter
  assign evt.tooth_edge = edge0;
  assign evt.pcnt_ovf   = trk_evt.pcnt_ovf;
  assign evt.gap_point  = trk_evt.gap_point;
  assign evt.sync_err   = trk_evt.sync_err;

  angle_gen u_angle (
    .clk           (clk),
    .rst_n         (rst_n),
    .edge0         (edge0),
    .edge1         (edge1),
    .started       (started),
    .gap_point_now (gap_point_now),
    .cfg           (cfg),
    .period        (period),
    .tooth         (tooth),
    .acnt          (acnt),
    .acnt_top      (acnt_top)
  );

endmodule

`default_nettype wire

//--- hdl/angle_gen.sv
// Crank angle interpolation between tooth edges
// Splits the last period into ticks and advances the angle on each tick
`timescale 1ns/1ps
`default_nettype none

`include "hwag_defines.svh"

module angle_gen
  import hwag_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      edge0,
  input  wire logic      edge1,
  input  wire logic      started,
  input  wire logic      gap_point_now,
  input  wire hwag_cfg_t cfg,
  input  wire pcnt_t     period,
  input  wire tcnt_t     tooth,
  output acnt_t          acnt,
  output logic           acnt_top
);

  logic [4:0] shift;
  scnt_t      scnt;
  scnt_t      scnt_top;
  logic       scnt_at_top;
  logic       scnt_ena;
  tckc_t      tckc;
  tckc_t      tick_base;
  tckc_t      tick_lim;
  logic       tick_full;
  logic       tick;
  logic       acnt_at_top;

  assign shift     = {1'b0, cfg.stwd} + 5'd2;
  assign scnt_top  = scnt_t'(period >> shift);
  assign tick_base = tckc_t'(4) << cfg.stwd;

  // The gap spans three normal teeth
  assign tick_lim  = gap_point_now ? tick_base + (tick_base << 1) : tick_base;

  assign scnt_ena  = started & ~tick_full;
  assign tick      = scnt_ena & scnt_at_top;

  // Counts 1..top so one tick every scnt_top cycles
  cmp_counter #(.cnt_t(scnt_t)) u_scnt (
    .clk      (clk),
    .rst_n    (rst_n),
    .ena      (scnt_ena),
    .clr      (~started),
    .load     (edge0 | tick),
    .load_val (scnt_t'(1)),
    .top      (scnt_top),
    .count    (scnt),
    .at_top   (scnt_at_top)
  );

  // Ticks this tooth, holds the angle once the limit is reached
  cmp_counter #(.cnt_t(tckc_t)) u_tckc (
    .clk      (clk),
    .rst_n    (rst_n),
    .ena      (tick),
    .clr      (edge0 | ~started),
    .load     (1'b0),
    .load_val (tckc),
    .top      (tick_lim),
    .count    (tckc),
    .at_top   (tick_full)
  );

  cmp_counter #(.cnt_t(acnt_t)) u_acnt (
    .clk      (clk),
    .rst_n    (rst_n),
    .ena      (tick),
    .clr      (tick & acnt_at_top),
    .load     (~started | edge1),
    .load_val (acnt_t'(tooth) << shift),
    .top      (acnt_t'(`HWAG_ACNT_TOP)),
    .count    (acnt),
    .at_top   (acnt_at_top)
  );

  assign acnt_top = tick & acnt_at_top;

endmodule

`default_nettype wire

//--- hdl/tooth_tracker.sv
// Tooth period measurement, missing-tooth search and tooth counting
// Latches sync on the first valid gap and then checks each gap position
`timescale 1ns/1ps
`default_nettype none

`include "hwag_defines.svh"

module tooth_tracker
  import hwag_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      edge0,
  input  wire hwag_cfg_t cfg,
  input  wire logic      thvl_load,
  input  wire tcnt_t     thvl_data,
  output pcnt_t          period,
  output tcnt_t          tooth,
  output logic           started,
  output logic           gap_point_now,
  output hwag_irq_t      evt
);

  pcnt_t pcnt;
  logic  pcnt_at_top;
  pcnt_t cap0;
  pcnt_t cap1;
  logic  cap_en;
  logic  start_hit;
  logic  tooth_step;
  logic  tooth_at_top;
  logic  gap_run;

  function automatic logic in_range(pcnt_t p, pcnt_t lo, pcnt_t hi);
    return (p >= lo) && (p <= hi);
  endfunction

  function automatic logic [31:0] scaled(pcnt_t p);
    return 32'(p) * `HWAG_GAP_RATIO;
  endfunction

  // Loads 1 on the edge so the captured value equals the cycle count
  cmp_counter #(.cnt_t(pcnt_t)) u_pcnt (
    .clk      (clk),
    .rst_n    (rst_n),
    .ena      (cfg.cape),
    .clr      (~cfg.cape),
    .load     (edge0),
    .load_val (pcnt_t'(1)),
    .top      ('1),
    .count    (pcnt),
    .at_top   (pcnt_at_top)
  );

  // No capture on the gap edge while synced
  assign cap_en = edge0 & cfg.cape & ~gap_point_now;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap0 <= '0;
      cap1 <= '0;
    end else if (!cfg.cape) begin
      cap0 <= '0;
      cap1 <= '0;
    end else if (cap_en) begin
      cap0 <= pcnt;
      cap1 <= cap0;
    end
  end

  // Checked on the two periods before the new one
  assign start_hit = edge0 & cfg.cape & ~started
                   & in_range(cap0, cfg.min_period, cfg.max_period)
                   & in_range(cap1, cfg.min_period, cfg.max_period)
                   & (32'(pcnt) > scaled(cap0))
                   & (32'(pcnt) > scaled(cap1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started <= 1'b0;
    end else if (!cfg.cape) begin
      started <= 1'b0;
    end else if (start_hit) begin
      started <= 1'b1;
    end
  end

  assign tooth_step = started & edge0;

  // Tooth zero follows the gap
  cmp_counter #(.cnt_t(tcnt_t)) u_tcnt (
    .clk      (clk),
    .rst_n    (rst_n),
    .ena      (tooth_step),
    .clr      (start_hit | (tooth_step & tooth_at_top)),
    .load     (thvl_load),
    .load_val (thvl_data),
    .top      (cfg.thnb),
    .count    (tooth),
    .at_top   (tooth_at_top)
  );

  assign gap_point_now = started & tooth_at_top;

  assign gap_run = tooth_step & (32'(pcnt) > scaled(cap0));

  assign period         = cap0;
  assign evt.tooth_edge = 1'b0;
  assign evt.pcnt_ovf   = pcnt_at_top & cfg.cape;
  assign evt.gap_point  = gap_run & tooth_at_top;
  assign evt.sync_err   = gap_run & ~tooth_at_top;

endmodule

`default_nettype wire

//--- hdl/hwag_regs.sv
// Host register file with set/clear control, interrupt enables and flags
// Decodes single-cycle bus strobes and drives the configuration to all blocks
`timescale 1ns/1ps
`default_nettype none

`include "hwag_defines.svh"

module hwag_regs
  import hwag_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire hwag_bus_req_t bus,
  output hwag_word_t         rdata,
  output hwag_cfg_t          cfg,
  input  wire hwag_irq_t     evt,
  input  wire pcnt_t         period,
  input  wire tcnt_t         tooth,
  output logic               thvl_load,
  output logic               irq
);

  hwag_word_t sfcr_q;
  hwag_word_t minl_q;
  hwag_word_t minh_q;
  hwag_word_t maxl_q;
  hwag_word_t maxh_q;
  hwag_word_t thnb_q;
  hwag_word_t stwd_q;
  hwag_word_t csr_q;
  hwag_word_t ier_q;
  hwag_word_t ifr_q;
  hwag_word_t ifr_set;
  hwag_word_t ifr_clr;
  logic [3:0] evt_bits;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sfcr_q <= '0;
      minl_q <= '0;
      minh_q <= '0;
      maxl_q <= '0;
      maxh_q <= '0;
      thnb_q <= '0;
      stwd_q <= '0;
      csr_q  <= '0;
      ier_q  <= '0;
    end else if (bus.we) begin
      case (bus.addr)
        `HWAG_A_SFCR: sfcr_q <= bus.wdata;
        `HWAG_A_MINL: minl_q <= bus.wdata;
        `HWAG_A_MINH: minh_q <= bus.wdata;
        `HWAG_A_MAXL: maxl_q <= bus.wdata;
        `HWAG_A_MAXH: maxh_q <= bus.wdata;
        `HWAG_A_THNB: thnb_q <= bus.wdata;
        `HWAG_A_STWD: stwd_q <= bus.wdata;
        // Only bits written as 1 change
        `HWAG_A_CSR:  csr_q  <= csr_q | bus.wdata;
        `HWAG_A_CCR:  csr_q  <= csr_q & ~bus.wdata;
        `HWAG_A_IESR: ier_q  <= ier_q | bus.wdata;
        `HWAG_A_IECR: ier_q  <= ier_q & ~bus.wdata;
        default: ;
      endcase
    end
  end

  // Flags latch enabled events, a new event wins over a write-1 clear
  assign evt_bits = evt;
  assign ifr_set  = {12'd0, evt_bits & ier_q[3:0]};
  assign ifr_clr  = (bus.we && bus.addr == `HWAG_A_IFR) ? bus.wdata : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ifr_q <= '0;
    end else begin
      ifr_q <= (ifr_q & ~ifr_clr) | ifr_set;
    end
  end

  assign irq = |ifr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (bus.re) begin
      case (bus.addr)
        `HWAG_A_SFCR:  rdata <= sfcr_q;
        `HWAG_A_MINL:  rdata <= minl_q;
        `HWAG_A_MINH:  rdata <= minh_q;
        `HWAG_A_MAXL:  rdata <= maxl_q;
        `HWAG_A_MAXH:  rdata <= maxh_q;
        `HWAG_A_THNB:  rdata <= thnb_q;
        `HWAG_A_STWD:  rdata <= stwd_q;
        `HWAG_A_CSR,
        `HWAG_A_CCR:   rdata <= csr_q;
        `HWAG_A_IESR,
        `HWAG_A_IECR:  rdata <= ier_q;
        `HWAG_A_IFR:   rdata <= ifr_q;
        `HWAG_A_PCNTL: rdata <= period[15:0];
        `HWAG_A_PCNTH: rdata <= {8'd0, period[23:16]};
        `HWAG_A_THVL:  rdata <= {8'd0, tooth};
        default:       rdata <= '0;
      endcase
    end
  end

  assign thvl_load = bus.we && (bus.addr == `HWAG_A_THVL);

  assign cfg.cape       = csr_q[0];
  assign cfg.edges      = csr_q[1];
  assign cfg.sflte      = csr_q[2];
  assign cfg.sfcr       = sfcr_q;
  assign cfg.min_period = pcnt_t'({minh_q, minl_q});
  assign cfg.max_period = pcnt_t'({maxh_q, maxl_q});
  assign cfg.thnb       = thnb_q[7:0];
  assign cfg.stwd       = stwd_q[3:0];

endmodule

`default_nettype wire

//--- hdl/vr_input_filter.sv
// Synchroniser, glitch filter and edge selection for the VR sensor pin
// Produces the filtered level and one-cycle active and opposite edge pulses
`timescale 1ns/1ps
`default_nettype none

module vr_input_filter
  import hwag_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      vr_in,
  input  wire hwag_cfg_t cfg,
  output logic           vr_out,
  output logic           edge0,
  output logic           edge1
);

  logic [1:0] sync_q;
  logic       filt_q;
  logic       out_q;
  hwag_word_t stab_cnt;
  logic       rise;
  logic       fall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q   <= '0;
      filt_q   <= 1'b0;
      stab_cnt <= '0;
      out_q    <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], vr_in};
      out_q  <= vr_out;
      if (!cfg.sflte) begin
        filt_q   <= sync_q[1];
        stab_cnt <= '0;
      end else if (sync_q[1] == filt_q) begin
        // Level bounced back so the count restarts
        stab_cnt <= '0;
      end else if (stab_cnt == cfg.sfcr) begin
        // New level held for sfcr+1 cycles
        filt_q   <= sync_q[1];
        stab_cnt <= '0;
      end else begin
        stab_cnt <= stab_cnt + 1'b1;
      end
    end
  end

  assign vr_out = filt_q & cfg.cape;

  assign rise = vr_out & ~out_q;
  assign fall = ~vr_out & out_q;

  // edges set means the falling edge is the tooth edge
  assign edge0 = cfg.edges ? fall : rise;
  assign edge1 = cfg.edges ? rise : fall;

endmodule

`default_nettype wire

//--- hdl/cmp_counter.sv
// Up counter with clear, load and compare against a top value
// Shared by the period, tooth, divider, tick and angle counters
`timescale 1ns/1ps
`default_nettype none

module cmp_counter #(
  parameter type cnt_t = logic [7:0]
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic ena,
  input  wire logic clr,
  input  wire logic load,
  input  wire cnt_t load_val,
  input  wire cnt_t top,
  output cnt_t      count,
  output logic      at_top
);

  // Clear beats load, load beats increment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clr) begin
      count <= '0;
    end else if (load) begin
      count <= load_val;
    end else if (ena) begin
      count <= count + 1'b1;
    end
  end

  assign at_top = (count == top);

endmodule

`default_nettype wire

//--- hdl/hwag_pkg.sv
// Shared types of the angle generator
// Imported by every block that carries bus, configuration or event signals
`default_nettype none

`include "hwag_defines.svh"

package hwag_pkg;

  typedef logic [15:0] hwag_word_t;

  // Counter widths
  typedef logic [`HWAG_PCNT_W-1:0] pcnt_t;
  typedef logic [7:0]  tcnt_t;
  typedef logic [21:0] scnt_t;
  typedef logic [18:0] tckc_t;
  typedef logic [23:0] acnt_t;

  // Single-cycle host access
  typedef struct packed {
    logic       we;
    logic       re;
    logic [7:0] addr;
    hwag_word_t wdata;
  } hwag_bus_req_t;

  // Decoded register contents
  typedef struct packed {
    logic       cape;
    logic       edges;
    logic       sflte;
    hwag_word_t sfcr;
    pcnt_t      min_period;
    pcnt_t      max_period;
    tcnt_t      thnb;
    logic [3:0] stwd;
  } hwag_cfg_t;

  // Event pulses, bit 0 is the lowest field and matches the IFR layout
  typedef struct packed {
    logic sync_err;
    logic gap_point;
    logic pcnt_ovf;
    logic tooth_edge;
  } hwag_irq_t;

endpackage

`default_nettype wire

//--- hdl/hwag_defines.svh
// Widths, register map and constants of the crank angle generator
// Included by the package and by every block that decodes addresses or limits
`ifndef HWAG_DEFINES_SVH
`define HWAG_DEFINES_SVH

// Period counter and capture width
`define HWAG_PCNT_W 24

// Last angle value before the counter wraps
`define HWAG_ACNT_TOP 3839

// A gap period must exceed this many normal periods
`define HWAG_GAP_RATIO 2

// Plain configuration registers
`define HWAG_A_SFCR  8'h00
`define HWAG_A_MINL  8'h01
`define HWAG_A_MINH  8'h02
`define HWAG_A_MAXL  8'h03
`define HWAG_A_MAXH  8'h04
`define HWAG_A_THNB  8'h05
`define HWAG_A_STWD  8'h06

// Set/clear pairs, flags and live values
`define HWAG_A_CSR   8'h40
`define HWAG_A_CCR   8'h41
`define HWAG_A_IESR  8'h42
`define HWAG_A_IECR  8'h43
`define HWAG_A_IFR   8'h44
`define HWAG_A_PCNTL 8'h45
`define HWAG_A_PCNTH 8'h46
`define HWAG_A_THVL  8'h47

`endif
